/* project.f */
+incdir+.
+incdir+testbench
source/aes_key_pkg.sv
source/aes_sbox.sv
source/aes_key_sequencer.sv
source/aes_word_generator.sv
source/aes_round_key_store.sv
source/aes_key_expansion.sv
testbench/aes_key_expansion_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the key expander testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f project.f \
    --top-module aes_key_expansion_tb \
    -o aes_key_expansion_sim

./obj_dir/aes_key_expansion_sim | tee sim.log

if grep -qx 'All tests passed!' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* testbench/aes_key_model.svh */
`ifndef AES_KEY_MODEL_SVH
`define AES_KEY_MODEL_SVH

logic [7:0]  sbox_tab [256];
logic [31:0] sched [`AES_MAX_WORDS];

function automatic logic [7:0] xtime(input logic [7:0] v);
    return {v[6:0], 1'b0} ^ (v[7] ? 8'h1b : 8'h00);
endfunction

// inverse from the powers of 03, then the affine map bit by bit
function automatic void build_sbox();
    logic [7:0] alog [255];
    int         log_of [256];
    logic [7:0] p;
    logic [7:0] inv;
    logic [7:0] s;
    p = 8'h01;
    for (int i = 0; i < 255; i++) begin
        alog[i]   = p;
        log_of[p] = i;
        p = p ^ xtime(p);  // times 03
    end
    for (int x = 0; x < 256; x++) begin
        inv = (x == 0) ? 8'h00 : alog[(255 - log_of[x]) % 255];
        for (int b = 0; b < 8; b++) begin
            s[b] = inv[b] ^ inv[(b + 4) % 8] ^ inv[(b + 5) % 8] ^ inv[(b + 6) % 8]
                 ^ inv[(b + 7) % 8];
        end
        sbox_tab[x] = s ^ 8'h63;
    end
endfunction

function automatic logic [31:0] sub_word(input logic [31:0] w);
    return {sbox_tab[w[31:24]], sbox_tab[w[23:16]], sbox_tab[w[15:8]], sbox_tab[w[7:0]]};
endfunction

// key words are taken from the top of the 256-bit input
function automatic void expand_key(input logic [`AES_KEY_W-1:0] key, input bit long_key);
    int          nk;
    int          total;
    logic [7:0]  rc;
    logic [31:0] t;
    nk    = long_key ? `AES_NK_256 : `AES_NK_128;
    total = long_key ? `AES_MAX_WORDS : `AES_NK_128 * (`AES_N_ROUND_128 + 1);
    rc    = 8'h01;
    for (int i = 0; i < total; i++) begin
        if (i < nk) begin
            sched[i] = key[`AES_KEY_W - 1 - 32 * i -: 32];
        end else begin
            t = sched[i-1];
            if (i % nk == 0) begin
                t  = sub_word({t[23:0], t[31:24]}) ^ {rc, 24'h000000};
                rc = xtime(rc);
            end else if (nk == 8 && i % 8 == 4) begin
                t = sub_word(t);
            end
            sched[i] = sched[i-nk] ^ t;
        end
    end
endfunction

function automatic logic [127:0] model_round_key(input int r);
    return {sched[4*r], sched[4*r+1], sched[4*r+2], sched[4*r+3]};
endfunction

`endif

/* testbench/aes_key_expansion_tb.sv */
`timescale 1ns/100ps
`include "aes_key_cfg.svh"

module aes_key_expansion_tb;
    import aes_key_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int READY_LIMIT  = 100;
    localparam int N_EXPANSIONS = 33;
    localparam int TEST_CYCLES  = N_EXPANSIONS * (3 + READY_LIMIT + 16) + 10;

    localparam logic [127:0] FIPS_KEY_128 = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam logic [255:0] FIPS_KEY_256 =
        256'h603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4;

    logic                    clk;
    logic                    rst;
    logic [`AES_KEY_W-1:0]   key_in;
    key_len_e                key_len;
    logic                    init;
    logic [`AES_ROUND_W-1:0] round;
    round_key_t              round_key;
    logic                    key_ready;
    logic [`AES_ROUND_W-1:0] round_num;
    int                      errors;

    `include "aes_key_model.svh"

    aes_key_expansion i_aes_key_expansion (
        .clk       (clk),
        .rst       (rst),
        .key_in    (key_in),
        .key_len   (key_len),
        .init      (init),
        .round     (round),
        .round_key (round_key),
        .key_ready (key_ready),
        .round_num (round_num)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("Watchdog expired at %0t before the tests finished", $time);
        $display("Errors: %0d", errors + 1);
        $display("Test failures found");
        $finish;
    end

    a_ready_low_after_reset: assert property (@(posedge clk) rst |=> !key_ready)
        else begin
            errors++;
            $display("Fail %0t key_ready expected 0 got %b", $time, $sampled(key_ready));
        end

    a_zero_while_not_ready: assert property (
        @(posedge clk) disable iff (rst) !key_ready |-> (round_key == '0)
    ) else begin
        errors++;
        $display("Fail %0t round_key expected 0 got %h", $time, $sampled(round_key));
    end

    a_round_num_legal: assert property (
        @(posedge clk) disable iff (rst)
        (round_num == 4'd10) || (round_num == 4'd14)
    ) else begin
        errors++;
        $display("Fail %0t round_num expected 10 or 14 got %0d", $time, $sampled(round_num));
    end

    // rounds past the last one must read zero
    task automatic check_round_keys(input int nr);
        round_key_t exp_key;
        for (int r = 0; r < 16; r++) begin
            @(posedge clk);
            round <= 4'(r);
            @(negedge clk);
            exp_key = (r <= nr) ? model_round_key(r) : '0;
            assert (round_key == exp_key) else begin
                errors++;
                $display("Fail %0t round_key round %0d expected %h got %h",
                         $time, r, exp_key, round_key);
            end
        end
    endtask

    // intrude_at > 0 pulses a second init that many edges into the expansion
    task automatic run_expansion(input logic [`AES_KEY_W-1:0] key, input logic [1:0] code,
                                 input int intrude_at, input logic [`AES_KEY_W-1:0] other_key);
        bit long_key;
        int nr;
        int rise_edge;
        int edges;
        long_key  = (code == 2'd2);
        nr        = long_key ? `AES_N_ROUND_256 : `AES_N_ROUND_128;
        rise_edge = long_key ? `AES_MAX_WORDS + 1 : `AES_NK_128 * (`AES_N_ROUND_128 + 1) + 1;
        expand_key(key, long_key);

        @(posedge clk);
        key_in  <= key;
        key_len <= key_len_e'(code);
        init    <= 1'b1;
        round   <= '0;
        @(posedge clk);  // init sampled here
        init  <= 1'b0;
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
            if (edges == intrude_at) begin
                key_in  <= other_key;
                key_len <= KEY_LEN_256;
                init    <= 1'b1;
            end else if (edges == intrude_at + 1) begin
                init <= 1'b0;
            end
            @(negedge clk);
            if (edges == 1) begin
                assert (!key_ready) else begin
                    errors++;
                    $display("Fail %0t key_ready expected 0 got %b", $time, key_ready);
                end
            end
        end while (!key_ready && edges < READY_LIMIT);

        assert (key_ready) else begin
            errors++;
            $display("key_ready did not rise within %0d edges of init at %0t",
                     READY_LIMIT, $time);
        end
        assert (edges == rise_edge) else begin
            errors++;
            $display("Fail %0t key_ready rise edge expected %0d got %0d",
                     $time, rise_edge, edges);
        end
        assert (round_num == 4'(nr)) else begin
            errors++;
            $display("Fail %0t round_num expected %0d got %0d", $time, nr, round_num);
        end
        check_round_keys(nr);
    endtask

    initial begin
        logic [`AES_KEY_W-1:0] key;
        logic [1:0]            code;
        errors  = 0;
        rst     = 1'b1;
        key_in  = '0;
        key_len = KEY_LEN_128;
        init    = 1'b0;
        round   = '0;
        void'($urandom(32'h30be47d7));
        build_sbox();

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!key_ready) else begin
            errors++;
            $display("Fail %0t key_ready expected 0 got %b", $time, key_ready);
        end

        // fips-197 appendix a.1 and a.3
        run_expansion({FIPS_KEY_128, 128'h0}, 2'd0, 0, '0);
        assert (model_round_key(10) == 128'hd014f9a8c9ee2589e13f0cc8b6630ca6) else begin
            errors++;
            $display("model schedule disagrees with the FIPS-197 AES-128 example");
        end
        run_expansion(FIPS_KEY_256, 2'd2, 0, '0);
        assert (model_round_key(14) == 128'hfe4890d1e6188d0b046df344706c631e) else begin
            errors++;
            $display("model schedule disagrees with the FIPS-197 AES-256 example");
        end

        // second init lands mid-expansion and must be dropped
        run_expansion({128'h000102030405060708090a0b0c0d0e0f, 128'h0}, 2'd0, 10, FIPS_KEY_256);

        for (int n = 0; n < 30; n++) begin
            for (int i = 0; i < 8; i++) begin
                key[32*i +: 32] = $urandom;
            end
            code = 2'($urandom);  // 1 and 3 act as aes-128
            run_expansion(key, code, 0, '0);
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* source/aes_key_expansion.sv */
`timescale 1ns/100ps
`include "aes_key_cfg.svh"

module aes_key_expansion (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`AES_KEY_W-1:0]   key_in,
    input  aes_key_pkg::key_len_e   key_len,
    input  logic                    init,
    input  logic [`AES_ROUND_W-1:0] round,
    output aes_key_pkg::round_key_t round_key,
    output logic                    key_ready,
    output logic [`AES_ROUND_W-1:0] round_num
);
    import aes_key_pkg::*;

    key_cmd_t   cmd;
    sched_ctl_t ctl;
    word_wr_t   wr;

    assign cmd.init    = init;
    assign cmd.key     = key_in;
    assign cmd.key_len = key_len;

    // decode
    aes_key_sequencer i_sequencer (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .ctl       (ctl),
        .round_num (round_num)
    );

    // execute
    aes_word_generator i_word_generator (
        .clk    (clk),
        .rst    (rst),
        .key_in (key_in),
        .ctl    (ctl),
        .wr     (wr)
    );

    // result
    aes_round_key_store i_round_key_store (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .round     (round),
        .round_key (round_key),
        .key_ready (key_ready)
    );

endmodule

/* source/aes_round_key_store.sv */
`timescale 1ns/100ps
`include "aes_key_cfg.svh"

module aes_round_key_store (
    input  logic                    clk,
    input  logic                    rst,
    input  aes_key_pkg::word_wr_t   wr,
    input  logic [`AES_ROUND_W-1:0] round,
    output aes_key_pkg::round_key_t round_key,
    output logic                    key_ready
);
    import aes_key_pkg::*;

    key_word_t               mem [`AES_MAX_WORDS];
    logic                    ready_q;
    logic [`AES_ROUND_W-1:0] max_round;
    logic [5:0]              base;

    assign base = {round, 2'b00};

    always_ff @(posedge clk) begin
        if (wr.valid) begin
            mem[wr.index] <= wr.word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_q   <= 1'b0;
            max_round <= '0;
        end else if (wr.valid) begin
            if (wr.last) begin
                ready_q   <= 1'b1;
                max_round <= wr.index[5:2];  // 43 -> 10, 59 -> 14
            end else if (wr.index == 6'd0) begin
                ready_q <= 1'b0;
            end
        end
    end

    // drops as soon as a new schedule is in flight
    assign key_ready = ready_q && !wr.valid;

    always_comb begin
        if (key_ready && round <= max_round) begin
            round_key = {mem[base], mem[base + 6'd1], mem[base + 6'd2], mem[base + 6'd3]};
        end else begin
            round_key = '0;
        end
    end

    a_index_in_range: assert property (
        @(posedge clk) disable iff (rst)
        wr.valid |-> (wr.index < `AES_MAX_WORDS)
    );

endmodule

/* source/aes_word_generator.sv */
`timescale 1ns/100ps
`include "aes_key_cfg.svh"

module aes_word_generator (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`AES_KEY_W-1:0]   key_in,
    input  aes_key_pkg::sched_ctl_t ctl,
    output aes_key_pkg::word_wr_t   wr
);
    import aes_key_pkg::*;

    logic [`AES_KEY_W-1:0] key_q;
    key_word_t             hist [8];   // hist[0] is the newest word
    logic [7:0]            rcon;
    key_word_t             prev;
    key_word_t             back_nk;
    key_word_t             load_word;
    key_word_t             sub_in;
    key_word_t             sub_out;
    key_word_t             mixed;
    key_word_t             next_word;

    assign prev    = hist[0];
    assign back_nk = ctl.nk8 ? hist[7] : hist[3];

    assign load_word = key_q[`AES_KEY_W - 1 - `AES_WORD_W * ctl.index[2:0] -: `AES_WORD_W];

    // rotword ahead of the shared sbox
    assign sub_in = (ctl.kind == KIND_ROT_SUB_RCON)
                  ? {prev[`AES_WORD_W-9:0], prev[`AES_WORD_W-1 -: 8]}
                  : prev;

    aes_sbox i_sbox (
        .word_in  (sub_in),
        .word_out (sub_out)
    );

    always_comb begin
        case (ctl.kind)
            KIND_ROT_SUB_RCON: mixed = sub_out ^ {rcon, {(`AES_WORD_W - 8){1'b0}}};
            KIND_SUB_ONLY:     mixed = sub_out;
            default:           mixed = prev;
        endcase
        next_word = (ctl.kind == KIND_LOAD) ? load_word : (mixed ^ back_nk);
    end

    // key follows the input until the schedule starts
    always_ff @(posedge clk) begin
        if (!ctl.valid) begin
            key_q <= key_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rcon <= 8'h01;
        end else if (ctl.start) begin
            rcon <= 8'h01;
        end else if (ctl.valid && ctl.kind == KIND_ROT_SUB_RCON) begin
            rcon <= {rcon[6:0], 1'b0} ^ (rcon[7] ? 8'h1b : 8'h00);  // xtime
        end
    end

    always_ff @(posedge clk) begin
        if (ctl.valid) begin
            hist[0] <= next_word;
            for (int i = 1; i < 8; i++) begin
                hist[i] <= hist[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr.valid <= 1'b0;
        end else begin
            wr.valid <= ctl.valid;
        end
        wr.index <= ctl.index;
        wr.last  <= ctl.last;
        wr.word  <= next_word;
    end

    a_quiet_after_reset: assert property (
        @(posedge clk) rst |=> !wr.valid && !ctl.valid
    );

endmodule

/* source/aes_key_sequencer.sv */
`timescale 1ns/100ps
`include "aes_key_cfg.svh"

module aes_key_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  aes_key_pkg::key_cmd_t   cmd,
    output aes_key_pkg::sched_ctl_t ctl,
    output logic [`AES_ROUND_W-1:0] round_num
);
    import aes_key_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXPAND,
        ST_DONE
    } state_e;

    state_e     state;
    logic [5:0] idx;
    logic       nk8_q;     // latched key length, 8-word key
    logic [5:0] last_idx;
    logic [5:0] nk;
    logic       is_load;
    logic       is_rcon;
    logic       is_sub;

    assign nk       = nk8_q ? 6'(`AES_NK_256) : 6'(`AES_NK_128);
    assign last_idx = nk8_q ? 6'(`AES_MAX_WORDS - 1)
                            : 6'(`AES_NK_128 * (`AES_N_ROUND_128 + 1) - 1);

    assign is_load = idx < nk;
    assign is_rcon = nk8_q ? (idx[2:0] == 3'd0) : (idx[1:0] == 2'd0);
    assign is_sub  = nk8_q && (idx[2:0] == 3'd4);  // aes-256 only

    assign round_num = nk8_q ? `AES_ROUND_W'(`AES_N_ROUND_256)
                             : `AES_ROUND_W'(`AES_N_ROUND_128);

    always_comb begin
        ctl.valid = (state == ST_EXPAND);
        ctl.start = ctl.valid && (idx == 6'd0);
        ctl.nk8   = nk8_q;
        ctl.index = idx;
        ctl.last  = ctl.valid && (idx == last_idx);
        if (is_load) begin
            ctl.kind = KIND_LOAD;
        end else if (is_rcon) begin
            ctl.kind = KIND_ROT_SUB_RCON;
        end else if (is_sub) begin
            ctl.kind = KIND_SUB_ONLY;
        end else begin
            ctl.kind = KIND_PLAIN;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            idx   <= '0;
            nk8_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd.init) begin
                        state <= ST_EXPAND;
                        idx   <= '0;
                        nk8_q <= (cmd.key_len == KEY_LEN_256);
                    end
                end
                ST_EXPAND: begin
                    idx <= idx + 6'd1;
                    if (idx == last_idx) begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    state <= ST_IDLE;  // one spare cycle before next init
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // load words form one unbroken run from the start of a schedule
    a_load_only_in_key: assert property (
        @(posedge clk) disable iff (rst)
        ctl.valid && (ctl.kind == KIND_LOAD) && !ctl.start
            |-> $past(ctl.valid && (ctl.kind == KIND_LOAD))
    );

endmodule

/* source/aes_sbox.sv */
`timescale 1ns/100ps

module aes_sbox (
    input  aes_key_pkg::key_word_t word_in,
    output aes_key_pkg::key_word_t word_out
);
    import aes_key_pkg::*;

    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] sh;
        acc = 8'h00;
        sh  = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;
            end
            sh = {sh[6:0], 1'b0} ^ (sh[7] ? 8'h1b : 8'h00);
        end
        return acc;
    endfunction

    // inverse as x^254, zero maps to zero
    function automatic logic [7:0] gf_inv(input logic [7:0] x);
        logic [7:0] x2;
        logic [7:0] x3;
        logic [7:0] x12;
        logic [7:0] x15;
        logic [7:0] x240;
        x2   = gf_mul(x, x);
        x3   = gf_mul(x2, x);
        x12  = gf_mul(gf_mul(x3, x3), gf_mul(x3, x3));
        x15  = gf_mul(x12, x3);
        x240 = gf_mul(x15, x15);      // x^30
        x240 = gf_mul(x240, x240);    // x^60
        x240 = gf_mul(x240, x240);    // x^120
        x240 = gf_mul(x240, x240);
        return gf_mul(gf_mul(x240, x12), x2);
    endfunction

    function automatic logic [7:0] rotl8(input logic [7:0] v, input int n);
        return (v << n) | (v >> (8 - n));
    endfunction

    function automatic logic [7:0] sub_byte(input logic [7:0] x);
        logic [7:0] b;
        b = gf_inv(x);
        return b ^ rotl8(b, 1) ^ rotl8(b, 2) ^ rotl8(b, 3) ^ rotl8(b, 4) ^ 8'h63;
    endfunction

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            word_out[8*i +: 8] = sub_byte(word_in[8*i +: 8]);
        end
    end

endmodule

/* source/aes_key_pkg.sv */
`include "aes_key_cfg.svh"

package aes_key_pkg;

    // codes 1 and 3 fall back to aes-128
    typedef enum logic [1:0] {
        KEY_LEN_128 = 2'd0,
        KEY_LEN_256 = 2'd2
    } key_len_e;

    typedef logic [`AES_WORD_W-1:0] key_word_t;

    // word 4r sits in the top bits
    typedef logic [4*`AES_WORD_W-1:0] round_key_t;

    typedef struct packed {
        logic                  init;
        logic [`AES_KEY_W-1:0] key;
        key_len_e              key_len;
    } key_cmd_t;

    typedef enum logic [1:0] {
        KIND_LOAD,
        KIND_ROT_SUB_RCON,
        KIND_SUB_ONLY,
        KIND_PLAIN
    } word_kind_e;

    typedef struct packed {
        logic       valid;
        logic       start;     // first word of a new schedule
        word_kind_e kind;
        logic       nk8;
        logic [5:0] index;
        logic       last;
    } sched_ctl_t;

    typedef struct packed {
        logic       valid;
        logic [5:0] index;
        logic       last;
        key_word_t  word;
    } word_wr_t;

endpackage

/* aes_key_cfg.svh */
`ifndef AES_KEY_CFG_SVH
`define AES_KEY_CFG_SVH

// schedule word and key input widths
`define AES_WORD_W      32
`define AES_KEY_W       256

// words in the longest schedule (aes-256)
`define AES_MAX_WORDS   60

`define AES_NK_128      4
`define AES_NK_256      8

`define AES_N_ROUND_128 10
`define AES_N_ROUND_256 14

`define AES_ROUND_W     4

`endif
